// File: output_buffer.sv
// Output FIFO and event counter
`timescale 1ns/1ps
`include "zs_defines.svh"

module output_buffer
	import zs_pkg::*;
(
	input  logic                  CLK,
	input  logic                  RSTb,
	input  logic                  all_clear,
	input  logic                  wr_valid,
	output logic                  wr_ready,
	input  out_word_u             wr_word,
	input  logic                  ev_done,
	output logic                  out_valid,
	input  logic                  out_ready,
	output out_word_u             out_word,
	output logic [`ZS_USED_W-1:0] used_words,
	output logic                  overflow_seen,
	input  logic                  ev_read,
	output logic                  event_present
);

	localparam int PTR_W = $clog2(`ZS_FIFO_DEPTH);

	logic [`ZS_OUT_W-1:0]    mem [`ZS_FIFO_DEPTH];
	logic [PTR_W:0]          wr_ptr;	// extra wrap bit
	logic [PTR_W:0]          rd_ptr;
	logic [`ZS_EV_CNT_W-1:0] ev_cnt;
	logic                    full;
	logic                    wr_fire;
	logic                    pop;
	logic                    load;

	// used_words counts the output register too
	assign full     = used_words == `ZS_FIFO_DEPTH;
	assign wr_ready = !full;
	assign wr_fire  = wr_valid && wr_ready;
	assign pop      = out_valid && out_ready;
	assign load     = wr_ptr != rd_ptr && (!out_valid || out_ready);

	assign event_present = ev_cnt != '0;

	always_ff @(posedge CLK)
	begin
		if (wr_fire)
			mem[wr_ptr[PTR_W-1:0]] <= wr_word;
		if (load)
			out_word <= mem[rd_ptr[PTR_W-1:0]];	// look-ahead register
	end

	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (!RSTb)
		begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			out_valid     <= 1'b0;
			used_words    <= '0;
			overflow_seen <= 1'b0;
			ev_cnt        <= '0;
		end
		else if (all_clear)
		begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			out_valid     <= 1'b0;
			used_words    <= '0;
			overflow_seen <= 1'b0;
			ev_cnt        <= '0;
		end
		else
		begin
			if (wr_fire)
				wr_ptr <= wr_ptr + 1'b1;
			if (load)
				rd_ptr <= rd_ptr + 1'b1;
			if (load)
				out_valid <= 1'b1;
			else if (pop)
				out_valid <= 1'b0;
			case ({wr_fire, pop})
				2'b10:   used_words <= used_words + 1'b1;
				2'b01:   used_words <= used_words - 1'b1;
				default: used_words <= used_words;
			endcase
			if (full)
				overflow_seen <= 1'b1;
			// saturating with increment first
			if (ev_done && ev_cnt != '1)
				ev_cnt <= ev_cnt + 1'b1;
			else if (ev_read && ev_cnt != '0)
				ev_cnt <= ev_cnt - 1'b1;
		end
	end

	// ring of pointers must never be full when a word goes in
	a_no_write_full: assert property (@(posedge CLK) disable iff (!RSTb)
		wr_fire |-> !(wr_ptr[PTR_W] != rd_ptr[PTR_W]
			&& wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]));

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the zero suppression testbench with Verilator

verilator --binary --timing --assert -f zs.f --top-module tb_zs -o tb_zs_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_zs_sim > sim.log 2>&1 || { cat sim.log; echo "simulator exited with error"; exit 1; }

cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1
grep -q "=== PASS ===" sim.log || exit 1
exit 0

// File: strip_sequencer.sv
// Event framing and strip numbering
`timescale 1ns/1ps
`include "zs_defines.svh"

module strip_sequencer
	import zs_pkg::*;
(
	input  logic         CLK,
	input  logic         RSTb,
	input  logic         all_clear,
	input  logic         in_valid,
	output logic         in_ready,
	input  frame_beat_t  in_beat,
	output logic         s1_valid,
	input  logic         s1_ready,
	output strip_stage_t s1,
	output logic         thr_rd_en,
	output strip_addr_t  thr_rd_addr,
	output logic         framing_error
);

	logic                 rdy_q;
	logic                 ev_open;
	logic [`ZS_ADDR_W:0]  strip_cnt;	// one extra bit to reach 128
	logic                 s1_free;
	logic                 accept;
	logic                 pass;
	logic                 stray;

	assign s1_free  = !s1_valid || s1_ready;
	assign in_ready = rdy_q && s1_free;
	assign accept   = in_valid && in_ready;

	// strips and trailers only count inside an open event
	assign pass  = accept && (in_beat.kind == BEAT_HDR || ev_open);
	assign stray = accept && in_beat.kind != BEAT_HDR && !ev_open;

	assign thr_rd_en   = pass && in_beat.kind == BEAT_STRIP;
	assign thr_rd_addr = strip_cnt[`ZS_ADDR_W-1:0];

	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (!RSTb)
		begin
			rdy_q         <= 1'b0;
			ev_open       <= 1'b0;
			strip_cnt     <= '0;
			s1_valid      <= 1'b0;
			framing_error <= 1'b0;
		end
		else if (all_clear)
		begin
			ev_open       <= 1'b0;
			strip_cnt     <= '0;
			s1_valid      <= 1'b0;
			framing_error <= 1'b0;
		end
		else
		begin
			rdy_q <= 1'b1;
			if (s1_free)
				s1_valid <= pass;
			if (stray)
				framing_error <= 1'b1;	// sticky until all_clear
			if (pass)
			begin
				case (in_beat.kind)
					BEAT_HDR:
					begin
						ev_open   <= 1'b1;
						strip_cnt <= '0;
					end
					BEAT_STRIP:
						strip_cnt <= strip_cnt + 1'b1;
					default:
						ev_open <= 1'b0;	// trailer closes the event
				endcase
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (pass)
		begin
			s1.kind     <= in_beat.kind;
			s1.data     <= in_beat.data;
			s1.baseline <= in_beat.baseline;
			s1.addr     <= strip_cnt[`ZS_ADDR_W-1:0];
		end
	end

	a_full_event: assert property (@(posedge CLK) disable iff (!RSTb)
		pass && in_beat.kind == BEAT_TRL |-> strip_cnt == `ZS_STRIPS);

	a_s1_hold: assert property (@(posedge CLK) disable iff (!RSTb)
		s1_valid && !s1_ready && !all_clear |=> s1_valid && $stable(s1));

endmodule

// File: tb_zs.sv
// Zero suppression testbench
`timescale 1ns/1ps
`include "zs_defines.svh"

module tb_zs
	import zs_pkg::*;
;

	localparam int ROWS     = 8;
	localparam int OVF_LAST = 6;	// last row of the overflow chain

	typedef struct packed
	{
		logic        bsub;
		logic [11:0] base;
		logic [3:0]  ch;
		logic [4:0]  mod;
		logic [12:0] hdr;
		logic [12:0] trl;
		logic [1:0]  pat;	// 0 ramp, 1 random, 2 all ones
		logic [15:0] stall;
		logic [3:0]  reads;
		logic        chain;	// next row follows without draining
	} row_t;

	logic                       CLK = 1'b0;
	logic                       RSTb;
	logic                       all_clear;
	logic                       in_valid;
	logic                       in_ready;
	frame_beat_t                in_beat;
	thr_write_t                 thr_wr;
	logic                       base_sub_en;
	logic [`ZS_CH_ID_W-1:0]     ch_id;
	logic [`ZS_MODULE_ID_W-1:0] module_id;
	logic                       out_valid;
	logic                       out_ready;
	out_word_u                  out_word;
	logic [`ZS_USED_W-1:0]      used_words;
	logic                       overflow_seen;
	logic                       framing_error;
	logic                       ev_read;
	logic                       event_present;
	logic                       expect_ovf;
	logic                       sync_chk;
	logic                       stall_go;
	logic [15:0]                stall_req;
	logic [15:0]                stall_left = '0;
	int                         err_cnt;
	int                         pending;
	int                         tb_err;
	int                         blocked;
	int                         cycles = 0;
	int                         cycle_limit;
	row_t                       rows [ROWS];

	always #10 CLK = ~CLK;

	// out_ready drops for a requested number of cycles
	always @(negedge CLK)
	begin
		if (stall_go)
			stall_left <= stall_req;
		else if (stall_left != 0)
			stall_left <= stall_left - 1'b1;
	end
	assign out_ready = stall_left == 0;

	always @(posedge CLK)
	begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit)
		begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("=== FAIL ===");
			$finish;
		end
	end

	zs_top i_dut (
		.CLK(CLK), .RSTb(RSTb), .all_clear(all_clear),
		.in_valid(in_valid), .in_ready(in_ready), .in_beat(in_beat),
		.thr_wr(thr_wr), .base_sub_en(base_sub_en), .ch_id(ch_id), .module_id(module_id),
		.out_valid(out_valid), .out_ready(out_ready), .out_word(out_word),
		.used_words(used_words), .overflow_seen(overflow_seen),
		.framing_error(framing_error), .ev_read(ev_read), .event_present(event_present)
	);

	zs_checker i_chk (
		.CLK(CLK), .RSTb(RSTb), .all_clear(all_clear),
		.in_valid(in_valid), .in_ready(in_ready), .in_beat(in_beat),
		.thr_wr(thr_wr), .base_sub_en(base_sub_en), .ch_id(ch_id), .module_id(module_id),
		.out_valid(out_valid), .out_ready(out_ready), .out_word(out_word),
		.used_words(used_words),
		.ev_read(ev_read), .event_present(event_present), .framing_error(framing_error),
		.overflow_seen(overflow_seen), .expect_ovf(expect_ovf), .sync_chk(sync_chk),
		.err_cnt(err_cnt), .pending(pending)
	);

	task automatic load_table();
		rows[0] = '{1'b1, 12'h0C0, 4'h3, 5'h11, 13'h1ABC, 13'h0DEF, 2'd0, 16'd0, 4'd0, 1'b0};
		rows[1] = '{1'b0, 12'h800, 4'hA, 5'h05, 13'h0123, 13'h1456, 2'd1, 16'd0, 4'd1, 1'b0};
		rows[2] = '{1'b1, 12'hF00, 4'h5, 5'h1F, 13'h1FFF, 13'h0ACE, 2'd1, 16'd40, 4'd0, 1'b0};
		rows[3] = '{1'b0, 12'h7FF, 4'hC, 5'h0A, 13'h0F0F, 13'h1234, 2'd2, 16'd0, 4'd4, 1'b0};
		rows[4] = '{1'b0, 12'h5A5, 4'h7, 5'h13, 13'h0111, 13'h0222, 2'd2, 16'd1500, 4'd0, 1'b1};
		rows[5] = '{1'b0, 12'h5A5, 4'h7, 5'h13, 13'h0333, 13'h0444, 2'd2, 16'd0, 4'd0, 1'b1};
		rows[6] = '{1'b0, 12'h5A5, 4'h7, 5'h13, 13'h0555, 13'h0666, 2'd2, 16'd0, 4'd1, 1'b0};
		rows[7] = '{1'b1, 12'h020, 4'h1, 5'h02, 13'h1001, 13'h0BEE, 2'd0, 16'd25, 4'd1, 1'b0};
	endtask

	function automatic logic [12:0] strip_data(input logic [1:0] pat, input int s);
		case (pat)
			2'd0:    return 13'(s * 64 + 17);
			2'd1:    return 13'($urandom);
			default: return 13'h1FFF;
		endcase
	endfunction

	task automatic send_beat(input beat_kind_e kind, input logic [12:0] data,
		input logic [11:0] base);
		@(negedge CLK);
		in_valid <= 1'b1;
		in_beat  <= {kind, data, base};
		#1;
		while (!in_ready)
		begin
			blocked = blocked + 1;
			@(negedge CLK);
			#1;
		end
		@(posedge CLK);	// beat transfers here
	endtask

	task automatic stop_stream();
		@(negedge CLK);
		in_valid <= 1'b0;
	endtask

	// every expected word popped and the output stall over
	task automatic wait_idle();
		while (pending != 0 || used_words != '0 || out_valid || stall_left != 0)
			@(negedge CLK);
	endtask

	task automatic start_stall(input logic [15:0] len);
		@(negedge CLK);
		stall_req <= len;
		stall_go  <= 1'b1;
		@(negedge CLK);
		stall_go  <= 1'b0;
	endtask

	task automatic read_event();
		@(negedge CLK);
		ev_read <= 1'b1;
		@(negedge CLK);
		ev_read <= 1'b0;
	endtask

	task automatic request_check();
		@(negedge CLK);
		sync_chk <= 1'b1;
		@(negedge CLK);
		sync_chk <= 1'b0;
	endtask

	task automatic clear_all();
		@(negedge CLK);
		all_clear <= 1'b1;
		@(negedge CLK);
		all_clear <= 1'b0;
	endtask

	task automatic play_row(input row_t row);
		@(negedge CLK);
		base_sub_en <= row.bsub;
		ch_id       <= row.ch;
		module_id   <= row.mod;
		if (row.stall != 0)
			start_stall(row.stall);
		send_beat(BEAT_HDR, row.hdr, row.base);
		for (int s = 0; s < `ZS_STRIPS; s++)
			send_beat(BEAT_STRIP, strip_data(row.pat, s), row.base);
		send_beat(BEAT_TRL, row.trl, row.base);
		stop_stream();
		if (!row.chain)
		begin
			wait_idle();
			repeat (row.reads) read_event();
			request_check();
		end
	endtask

	initial
	begin
		RSTb        = 1'b0;
		all_clear   = 1'b0;
		in_valid    = 1'b0;
		in_beat     = '0;
		thr_wr      = '0;
		base_sub_en = 1'b0;
		ch_id       = '0;
		module_id   = '0;
		ev_read     = 1'b0;
		expect_ovf  = 1'b0;
		sync_chk    = 1'b0;
		stall_go    = 1'b0;
		stall_req   = '0;
		tb_err      = 0;
		blocked     = 0;
		void'($urandom(32'hc96d));
		load_table();
		cycle_limit = 128 + 600 * ROWS + 600;	// extra for reset and end phases
		for (int r = 0; r < ROWS; r++)
			cycle_limit = cycle_limit + int'(rows[r].stall);
		repeat (10) @(posedge CLK);
		@(negedge CLK);
		RSTb <= 1'b1;
		repeat (3) @(negedge CLK);

		// random thresholds with roughly one in sixteen disabled
		for (int a = 0; a < `ZS_STRIPS; a++)
		begin
			@(negedge CLK);
			thr_wr.we   <= 1'b1;
			thr_wr.addr <= 7'(a);
			thr_wr.data <= ($urandom % 16 == 0) ? `ZS_THR_DISABLE : 12'($urandom % 1024);
		end
		@(negedge CLK);
		thr_wr <= '0;

		send_beat(BEAT_STRIP, 13'h1555, 12'h000);	// no header yet
		stop_stream();
		wait_idle();
		request_check();

		for (int r = 0; r < ROWS; r++)
		begin
			if (rows[r].stall > 16'd1000)
			begin
				blocked    = 0;
				expect_ovf <= 1'b1;
			end
			play_row(rows[r]);
			if (r == OVF_LAST && blocked < 20)
			begin
				tb_err = tb_err + 1;
				$display("in_ready never held off input while the output was stalled");
			end
		end

		if (pending != 0)
		begin
			tb_err = tb_err + 1;
			$display("%0d expected output words never arrived", pending);
		end
		clear_all();
		expect_ovf <= 1'b0;
		repeat (2) @(negedge CLK);
		request_check();
		repeat (4) @(negedge CLK);

		$display("errors: %0d checker, %0d testbench", err_cnt, tb_err);
		if (err_cnt == 0 && tb_err == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: threshold_ram.sv
// Strip threshold memory
`timescale 1ns/1ps

module threshold_ram
	import zs_pkg::*;
(
	input  logic        CLK,
	input  thr_write_t  thr_wr,
	input  logic        rd_en,
	input  strip_addr_t rd_addr,
	output sample_t     rd_data
);

	localparam int DEPTH = 2 ** $bits(strip_addr_t);

	sample_t mem [DEPTH];

	// host write port
	always_ff @(posedge CLK)
	begin
		if (thr_wr.we)
			mem[thr_wr.addr] <= thr_wr.data;
	end

	// read register only moves on a new strip
	always_ff @(posedge CLK)
	begin
		if (rd_en)
			rd_data <= mem[rd_addr];	// old data on a same-address write
	end

endmodule

// File: zero_suppressor.sv
// Baseline subtraction and threshold cut
`timescale 1ns/1ps
`include "zs_defines.svh"

module zero_suppressor
	import zs_pkg::*;
(
	input  logic                       CLK,
	input  logic                       RSTb,
	input  logic                       all_clear,
	input  logic                       s1_valid,
	output logic                       s1_ready,
	input  strip_stage_t               s1,
	input  sample_t                    thr_data,
	input  logic                       base_sub_en,
	input  logic [`ZS_CH_ID_W-1:0]     ch_id,
	input  logic [`ZS_MODULE_ID_W-1:0] module_id,
	output logic                       wr_valid,
	input  logic                       wr_ready,
	output out_word_u                  wr_word,
	output logic                       ev_done
);

	sample_t                sub_base;
	logic [`ZS_RAW_W:0]     diff;	// sign bit on top
	logic                   is_hit;
	logic                   is_trl;
	logic                   out_free;
	logic                   consume;
	logic                   trl_second;	// second trailer word pending
	logic                   out_last;
	logic [7:0]             word_cnt;
	out_word_u              nxt_word;

	assign sub_base = base_sub_en ? s1.baseline : '0;
	assign diff     = {1'b0, s1.data} - {2'b00, sub_base};
	assign is_hit   = thr_data != `ZS_THR_DISABLE && !diff[`ZS_RAW_W]
		&& diff[`ZS_SAMPLE_W-1:0] > thr_data;

	assign is_trl   = s1.kind == BEAT_TRL;
	assign out_free = !wr_valid || wr_ready;
	// a trailer stays in s1 while its first word goes out
	assign s1_ready = out_free && !(s1_valid && is_trl && !trl_second);
	assign consume  = s1_valid && s1_ready;

	assign ev_done  = wr_valid && wr_ready && out_last;

	always_comb
	begin
		nxt_word = '0;
		case (s1.kind)
			BEAT_HDR:
			begin
				nxt_word.hdr.zero     = 3'b000;
				nxt_word.hdr.base_msb = s1.baseline[`ZS_SAMPLE_W-1];
				nxt_word.hdr.data     = s1.data;
				nxt_word.hdr.ch_id    = ch_id;
			end
			BEAT_STRIP:
			begin
				nxt_word.hit.tag   = 2'b01;
				nxt_word.hit.addr  = s1.addr;
				nxt_word.hit.value = diff[`ZS_SAMPLE_W-1:0];
			end
			default:
			begin
				if (trl_second)
				begin
					nxt_word.trl_b.tag     = 2'b11;
					nxt_word.trl_b.base_lo = s1.baseline[`ZS_SAMPLE_W-2:0];
					nxt_word.trl_b.count   = word_cnt;
				end
				else
				begin
					nxt_word.trl_a.tag       = 2'b10;
					nxt_word.trl_a.zero      = 2'b00;
					nxt_word.trl_a.module_id = module_id;
					nxt_word.trl_a.data      = s1.data[`ZS_SAMPLE_W-1:0];
				end
			end
		endcase
	end

	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (!RSTb)
		begin
			wr_valid   <= 1'b0;
			out_last   <= 1'b0;
			trl_second <= 1'b0;
			word_cnt   <= '0;
		end
		else if (all_clear)
		begin
			wr_valid   <= 1'b0;
			out_last   <= 1'b0;
			trl_second <= 1'b0;
			word_cnt   <= '0;
		end
		else
		begin
			if (out_free)
			begin
				wr_valid <= s1_valid && (s1.kind != BEAT_STRIP || is_hit);
				out_last <= s1_valid && is_trl && trl_second;
				if (s1_valid && is_trl)
					trl_second <= !trl_second;
			end
			if (consume && s1.kind == BEAT_HDR)
				word_cnt <= 8'd2;	// both trailer words counted
			else if (consume && s1.kind == BEAT_STRIP && is_hit)
				word_cnt <= word_cnt + 1'b1;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (out_free && s1_valid)
			wr_word <= nxt_word;
	end

	a_word_hold: assert property (@(posedge CLK) disable iff (!RSTb)
		wr_valid && !wr_ready && !all_clear |=> wr_valid && $stable(wr_word));

endmodule

// File: zs.f
+incdir+.
zs_pkg.sv
threshold_ram.sv
strip_sequencer.sv
zero_suppressor.sv
output_buffer.sv
zs_top.sv
zs_checker.sv
tb_zs.sv

// File: zs_checker.sv
// Expected output model
`timescale 1ns/1ps
`include "zs_defines.svh"

module zs_checker
	import zs_pkg::*;
(
	input  logic                       CLK,
	input  logic                       RSTb,
	input  logic                       all_clear,
	input  logic                       in_valid,
	input  logic                       in_ready,
	input  frame_beat_t                in_beat,
	input  thr_write_t                 thr_wr,
	input  logic                       base_sub_en,
	input  logic [`ZS_CH_ID_W-1:0]     ch_id,
	input  logic [`ZS_MODULE_ID_W-1:0] module_id,
	input  logic                       out_valid,
	input  logic                       out_ready,
	input  out_word_u                  out_word,
	input  logic [`ZS_USED_W-1:0]      used_words,
	input  logic                       ev_read,
	input  logic                       event_present,
	input  logic                       framing_error,
	input  logic                       overflow_seen,
	input  logic                       expect_ovf,
	input  logic                       sync_chk,
	output int                         err_cnt,
	output int                         pending
);

	sample_t              thr_mem [`ZS_STRIPS];
	logic [`ZS_OUT_W-1:0] exp_q [$];
	logic                 ev_open;
	strip_addr_t          strip_no;
	logic [7:0]           word_cnt;
	int                   exp_ev;
	logic                 exp_fe;

	assign pending = exp_q.size();

	task automatic clear_model();
		exp_q.delete();
		ev_open  = 1'b0;
		strip_no = '0;
		word_cnt = '0;
		exp_ev   = 0;
		exp_fe   = 1'b0;
	endtask

	task automatic model_beat();
		int diff;
		sample_t thr;
		thr = thr_mem[strip_no];
		diff = int'(in_beat.data) - (base_sub_en ? int'(in_beat.baseline) : 0);
		case (in_beat.kind)
			BEAT_HDR:
			begin
				exp_q.push_back({3'b000, in_beat.baseline[11], in_beat.data, ch_id});
				ev_open  = 1'b1;
				strip_no = '0;
				word_cnt = 8'd2;
			end
			BEAT_STRIP:
			begin
				if (!ev_open)
					exp_fe = 1'b1;	// stray strip makes no word
				else
				begin
					if (thr != `ZS_THR_DISABLE && diff >= 0 && diff[11:0] > thr)
					begin
						exp_q.push_back({2'b01, strip_no, diff[11:0]});
						word_cnt = word_cnt + 1'b1;
					end
					strip_no = strip_no + 1'b1;
				end
			end
			default:
			begin
				if (!ev_open)
					exp_fe = 1'b1;
				else
				begin
					exp_q.push_back({2'b10, 2'b00, module_id, in_beat.data[11:0]});
					exp_q.push_back({2'b11, in_beat.baseline[10:0], word_cnt});
					if (exp_ev < 31)
						exp_ev = exp_ev + 1;
					ev_open = 1'b0;
				end
			end
		endcase
	endtask

	task automatic show_mismatch(input logic [`ZS_OUT_W-1:0] exp_raw);
		out_word_u e;
		e = exp_raw;
		case (exp_raw[20:19])
			2'b00: $display("ERR out_word.hdr base_msb/data/ch_id exp %h/%h/%h got %h/%h/%h",
				e.hdr.base_msb, e.hdr.data, e.hdr.ch_id,
				out_word.hdr.base_msb, out_word.hdr.data, out_word.hdr.ch_id);
			2'b01: $display("ERR out_word.hit addr/value exp %h/%h got %h/%h",
				e.hit.addr, e.hit.value, out_word.hit.addr, out_word.hit.value);
			2'b10: $display("ERR out_word.trl_a module_id/data exp %h/%h got %h/%h",
				e.trl_a.module_id, e.trl_a.data, out_word.trl_a.module_id, out_word.trl_a.data);
			default: $display("ERR out_word.trl_b base_lo/count exp %h/%h got %h/%h",
				e.trl_b.base_lo, e.trl_b.count, out_word.trl_b.base_lo, out_word.trl_b.count);
		endcase
		$display("ERR out_word exp %h got %h", exp_raw, out_word);
	endtask

	task automatic check_pop();
		logic [`ZS_OUT_W-1:0] exp_raw;
		if (exp_q.size() == 0)
		begin
			err_cnt = err_cnt + 1;
			$display("unexpected output word %h arrived with nothing expected", out_word);
		end
		else
		begin
			exp_raw = exp_q.pop_front();
			if (exp_raw != out_word)
			begin
				err_cnt = err_cnt + 1;
				show_mismatch(exp_raw);
			end
		end
	endtask

	// s1 and the suppressor register hold at most three words ahead of the FIFO
	task automatic check_fill();
		int lo;
		int hi;
		hi = exp_q.size();
		lo = (hi > 3) ? hi - 3 : 0;
		if (int'(used_words) < lo || int'(used_words) > hi)
		begin
			err_cnt = err_cnt + 1;
			$display("ERR used_words exp %h to %h got %h", lo, hi, used_words);
		end
	endtask

	task automatic check_status();
		if (event_present != (exp_ev != 0))
		begin
			err_cnt = err_cnt + 1;
			$display("ERR event_present exp %h got %h", exp_ev != 0, event_present);
		end
		if (framing_error != exp_fe)
		begin
			err_cnt = err_cnt + 1;
			$display("ERR framing_error exp %h got %h", exp_fe, framing_error);
		end
		if (overflow_seen != expect_ovf)
		begin
			err_cnt = err_cnt + 1;
			$display("ERR overflow_seen exp %h got %h", expect_ovf, overflow_seen);
		end
	endtask

	always @(posedge CLK)
	begin
		if (!RSTb)
		begin
			clear_model();
			err_cnt = 0;
		end
		else if (all_clear)
			clear_model();
		else
		begin
			check_fill();
			if (thr_wr.we)
				thr_mem[thr_wr.addr] = thr_wr.data;	// host copy
			if (out_valid && out_ready)
				check_pop();
			if (in_valid && in_ready)
				model_beat();
			if (ev_read && exp_ev > 0)
				exp_ev = exp_ev - 1;
			if (sync_chk)
				check_status();
		end
	end

endmodule

// File: zs_defines.svh
// Zero suppression parameters
`ifndef ZS_DEFINES_SVH
`define ZS_DEFINES_SVH

// event geometry
`define ZS_STRIPS       128
`define ZS_ADDR_W       7

// data paths
`define ZS_SAMPLE_W     12
`define ZS_RAW_W        13
`define ZS_OUT_W        21

// output buffer
`define ZS_FIFO_DEPTH   256
`define ZS_USED_W       9
`define ZS_EV_CNT_W     5

// threshold code that masks a strip
`define ZS_THR_DISABLE  12'hFFF

// board identification fields
`define ZS_CH_ID_W      4
`define ZS_MODULE_ID_W  5

`endif

// File: zs_pkg.sv
// Zero suppression types
`include "zs_defines.svh"

package zs_pkg;

	typedef logic [`ZS_ADDR_W-1:0]   strip_addr_t;
	typedef logic [`ZS_SAMPLE_W-1:0] sample_t;

	typedef enum logic [1:0]
	{
		BEAT_HDR   = 2'd0,
		BEAT_STRIP = 2'd1,
		BEAT_TRL   = 2'd2
	} beat_kind_e;

	typedef struct packed
	{
		beat_kind_e            kind;
		logic [`ZS_RAW_W-1:0]  data;
		sample_t               baseline;
	} frame_beat_t;

	typedef struct packed
	{
		logic                  we;
		strip_addr_t           addr;
		sample_t               data;
	} thr_write_t;

	// one beat on its way to the suppressor, strip number attached
	typedef struct packed
	{
		beat_kind_e            kind;
		logic [`ZS_RAW_W-1:0]  data;
		sample_t               baseline;
		strip_addr_t           addr;
	} strip_stage_t;

	typedef struct packed
	{
		logic [2:0]                zero;
		logic                      base_msb;
		logic [`ZS_RAW_W-1:0]      data;
		logic [`ZS_CH_ID_W-1:0]    ch_id;
	} hdr_word_t;

	typedef struct packed
	{
		logic [1:0]                tag;	// 2'b01
		strip_addr_t               addr;
		sample_t                   value;
	} hit_word_t;

	typedef struct packed
	{
		logic [1:0]                tag;	// 2'b10
		logic [1:0]                zero;
		logic [`ZS_MODULE_ID_W-1:0] module_id;
		sample_t                   data;
	} trl_a_word_t;

	typedef struct packed
	{
		logic [1:0]                tag;	// 2'b11
		logic [`ZS_SAMPLE_W-2:0]   base_lo;
		logic [7:0]                count;
	} trl_b_word_t;

	typedef union packed
	{
		hdr_word_t                 hdr;
		hit_word_t                 hit;
		trl_a_word_t               trl_a;
		trl_b_word_t               trl_b;
	} out_word_u;

endpackage

// File: zs_top.sv
// Zero suppression channel top
`timescale 1ns/1ps
`include "zs_defines.svh"

module zs_top
	import zs_pkg::*;
(
	input  logic                       CLK,
	input  logic                       RSTb,
	input  logic                       all_clear,
	input  logic                       in_valid,
	output logic                       in_ready,
	input  frame_beat_t                in_beat,
	input  thr_write_t                 thr_wr,
	input  logic                       base_sub_en,
	input  logic [`ZS_CH_ID_W-1:0]     ch_id,
	input  logic [`ZS_MODULE_ID_W-1:0] module_id,
	output logic                       out_valid,
	input  logic                       out_ready,
	output out_word_u                  out_word,
	output logic [`ZS_USED_W-1:0]      used_words,
	output logic                       overflow_seen,
	output logic                       framing_error,
	input  logic                       ev_read,
	output logic                       event_present
);

	logic         s1_valid;
	logic         s1_ready;
	strip_stage_t s1;
	logic         thr_rd_en;
	strip_addr_t  thr_rd_addr;
	sample_t      thr_data;
	logic         wr_valid;
	logic         wr_ready;
	out_word_u    wr_word;
	logic         ev_done;

	strip_sequencer i_seq (
		.CLK(CLK), .RSTb(RSTb), .all_clear(all_clear),
		.in_valid(in_valid), .in_ready(in_ready), .in_beat(in_beat),
		.s1_valid(s1_valid), .s1_ready(s1_ready), .s1(s1),
		.thr_rd_en(thr_rd_en), .thr_rd_addr(thr_rd_addr),
		.framing_error(framing_error)
	);

	threshold_ram i_thr (
		.CLK(CLK), .thr_wr(thr_wr),
		.rd_en(thr_rd_en), .rd_addr(thr_rd_addr), .rd_data(thr_data)
	);

	zero_suppressor i_zs (
		.CLK(CLK), .RSTb(RSTb), .all_clear(all_clear),
		.s1_valid(s1_valid), .s1_ready(s1_ready), .s1(s1), .thr_data(thr_data),
		.base_sub_en(base_sub_en), .ch_id(ch_id), .module_id(module_id),
		.wr_valid(wr_valid), .wr_ready(wr_ready), .wr_word(wr_word),
		.ev_done(ev_done)
	);

	output_buffer i_buf (
		.CLK(CLK), .RSTb(RSTb), .all_clear(all_clear),
		.wr_valid(wr_valid), .wr_ready(wr_ready), .wr_word(wr_word),
		.ev_done(ev_done),
		.out_valid(out_valid), .out_ready(out_ready), .out_word(out_word),
		.used_words(used_words), .overflow_seen(overflow_seen),
		.ev_read(ev_read), .event_present(event_present)
	);

endmodule
